/* build.f */
rtl/audio_pkg.sv
rtl/sample_ram.sv
rtl/aud_recorder.sv
rtl/aud_player.sv
rtl/aud_ctrl_regs.sv
rtl/aud_top.sv
tb/aud_props.sv
tb/aud_tb.sv

/* rtl/aud_ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module aud_ctrl_regs #(
	parameter int ADDR_W = 10
) (
	input  wire                                i_clk,
	input  wire                                i_rst_n,
	input  wire                                i_awvalid,
	input  wire  [audio_pkg::AXI_ADDR_W-1:0]   i_awaddr,
	input  wire                                i_wvalid,
	input  wire  [audio_pkg::AXI_DATA_W-1:0]   i_wdata,
	input  wire  [audio_pkg::AXI_DATA_W/8-1:0] i_wstrb,
	input  wire                                i_bready,
	input  wire                                i_arvalid,
	input  wire  [audio_pkg::AXI_ADDR_W-1:0]   i_araddr,
	input  wire                                i_rready,
	output logic                               o_awready,
	output logic                               o_wready,
	output logic                               o_bvalid,
	output logic [1:0]                         o_bresp,
	output logic                               o_arready,
	output logic                               o_rvalid,
	output logic [audio_pkg::AXI_DATA_W-1:0]   o_rdata,
	output logic [1:0]                         o_rresp,
	output logic                               o_start,
	output logic                               o_pause,
	output logic                               o_stop,
	output logic                               o_play,
	output logic [ADDR_W:0]                    o_limit,
	output logic [ADDR_W-1:0]                  o_rd_addr,
	input  var   audio_pkg::rec_state_e        i_state,
	input  wire  [ADDR_W:0]                    i_count,
	input  wire                                i_done,
	input  wire                                i_busy,
	input  wire  [audio_pkg::SAMPLE_W-1:0]     i_rd_data
);

	localparam int DATA_W = audio_pkg::AXI_DATA_W;
	localparam logic [DATA_W-1:0] LIMIT_MAX = DATA_W'(2 ** ADDR_W);    // Whole memory

	logic                           wr_fire;
	logic                           rd_fire;
	logic [DATA_W-1:0]              wmask;
	logic [DATA_W-1:0]              wr_limit;
	logic [DATA_W-1:0]              wr_rdaddr;
	logic [DATA_W-1:0]              status;
	logic [DATA_W-1:0]              rd_word;
	logic [DATA_W-1:0]              rdata_q;
	logic [audio_pkg::SAMPLE_W-1:0] rd_hold;
	logic                           rd_ok;
	logic                           rd_is_mem;
	logic                           rd_mem;
	logic                           rd_first;    // First RVALID cycle of a memory read

	assign wr_fire   = i_awvalid & i_wvalid & ~o_bvalid;
	assign o_awready = wr_fire;
	assign o_wready  = wr_fire;
	assign rd_fire   = i_arvalid & ~o_rvalid;
	assign o_arready = rd_fire;

	always_comb begin
		for (int b = 0; b < DATA_W / 8; b++) begin
			wmask[8*b +: 8] = {8{i_wstrb[b]}};
		end
	end

	assign wr_limit  = (DATA_W'(o_limit) & ~wmask) | (i_wdata & wmask);
	assign wr_rdaddr = (DATA_W'(o_rd_addr) & ~wmask) | (i_wdata & wmask);

	always_comb begin
		status = '0;
		status[audio_pkg::STAT_REC_STATE +: 2] = i_state;
		status[audio_pkg::STAT_PLAYING]        = i_busy;
		status[audio_pkg::STAT_DONE]           = i_done;
		status[audio_pkg::STAT_COUNT +: ADDR_W+1] = i_count;
	end

	always_comb begin
		rd_word   = '0;
		rd_ok     = 1'b1;
		rd_is_mem = 1'b0;
		case (i_araddr)
			audio_pkg::REG_CTRL:   rd_word = '0;    // Commands read back as zero
			audio_pkg::REG_STATUS: rd_word = status;
			audio_pkg::REG_LIMIT:  rd_word = DATA_W'(o_limit);
			audio_pkg::REG_RDADDR: rd_word = DATA_W'(o_rd_addr);
			audio_pkg::REG_RDDATA: rd_is_mem = 1'b1;
			default:               rd_ok = 1'b0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bvalid  <= 1'b0;
			o_bresp   <= audio_pkg::RESP_OKAY;
			o_start   <= 1'b0;
			o_pause   <= 1'b0;
			o_stop    <= 1'b0;
			o_play    <= 1'b0;
			o_limit   <= LIMIT_MAX[ADDR_W:0];
			o_rd_addr <= '0;
		end else begin
			o_start <= 1'b0;
			o_pause <= 1'b0;
			o_stop  <= 1'b0;
			o_play  <= 1'b0;
			if (o_bvalid && i_bready) begin
				o_bvalid <= 1'b0;
			end
			if (wr_fire) begin
				o_bvalid <= 1'b1;
				o_bresp  <= audio_pkg::RESP_OKAY;
				case (i_awaddr)
					audio_pkg::REG_CTRL: begin
						if (i_wstrb[0]) begin
							o_start <= i_wdata[audio_pkg::CTRL_START];
							o_pause <= i_wdata[audio_pkg::CTRL_PAUSE];
							o_stop  <= i_wdata[audio_pkg::CTRL_STOP];
							o_play  <= i_wdata[audio_pkg::CTRL_PLAY];
						end
					end
					audio_pkg::REG_LIMIT: begin
						o_limit <= (wr_limit > LIMIT_MAX) ? LIMIT_MAX[ADDR_W:0] :
							wr_limit[ADDR_W:0];
					end
					audio_pkg::REG_RDADDR: o_rd_addr <= wr_rdaddr[ADDR_W-1:0];
					audio_pkg::REG_STATUS, audio_pkg::REG_RDDATA: ;
					default: o_bresp <= audio_pkg::RESP_SLVERR;
				endcase
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rvalid <= 1'b0;
			o_rresp  <= audio_pkg::RESP_OKAY;
			rd_mem   <= 1'b0;
			rd_first <= 1'b0;
		end else begin
			rd_first <= 1'b0;
			if (o_rvalid && i_rready) begin
				o_rvalid <= 1'b0;
			end
			if (rd_fire) begin
				o_rvalid <= 1'b1;
				o_rresp  <= rd_ok ? audio_pkg::RESP_OKAY : audio_pkg::RESP_SLVERR;
				rd_mem   <= rd_is_mem;
				rd_first <= rd_is_mem;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd_fire) begin
			rdata_q <= rd_word;
		end
		if (rd_first) begin
			rd_hold <= i_rd_data;    // Keep the sample while RREADY is low
		end
	end

	assign o_rdata = !rd_mem ? rdata_q :
		rd_first ? DATA_W'(i_rd_data) : DATA_W'(rd_hold);

endmodule

`default_nettype wire

/* rtl/aud_player.sv */
`timescale 1ns/1ns
`default_nettype none

module aud_player #(
	parameter int ADDR_W = 10
) (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_lrc,
	input  wire                            i_play,
	input  wire  [ADDR_W:0]                i_count,
	input  wire  [audio_pkg::SAMPLE_W-1:0] i_rd_data,
	output logic [ADDR_W-1:0]              o_rd_addr,
	output logic                           o_dacdat,
	output logic                           o_busy
);

	localparam int SAMPLE_W = audio_pkg::SAMPLE_W;
	localparam int BIT_W    = $clog2(SAMPLE_W + 1);

	logic                lrc_q;
	logic                lrc_fall;
	logic [BIT_W-1:0]    bits_left;
	logic [SAMPLE_W-1:0] shift;
	logic [ADDR_W:0]     total;
	logic [ADDR_W:0]     sent;
	logic                data_ready;    // Read port has caught up with o_rd_addr
	logic                load;

	assign lrc_fall = lrc_q & ~i_lrc;
	assign load     = o_busy & ~i_play & data_ready & lrc_fall &
		(bits_left == '0) & (sent != total);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lrc_q      <= 1'b0;
			o_busy     <= 1'b0;
			o_dacdat   <= 1'b0;
			o_rd_addr  <= '0;
			bits_left  <= '0;
			sent       <= '0;
			total      <= '0;
			data_ready <= 1'b0;
		end else begin
			lrc_q      <= i_lrc;
			data_ready <= ~(i_play | load);
			if (i_play) begin
				o_busy    <= (i_count != '0);
				total     <= i_count;
				sent      <= '0;
				o_rd_addr <= '0;    // Prefetch the first sample
				bits_left <= '0;
				o_dacdat  <= 1'b0;
			end else if (o_busy) begin
				if (bits_left != '0) begin
					o_dacdat  <= shift[SAMPLE_W-1];
					bits_left <= bits_left - 1'b1;
				end else begin
					o_dacdat <= 1'b0;
					if (sent == total) begin
						o_busy <= 1'b0;
					end else if (load) begin
						bits_left <= BIT_W'(SAMPLE_W);
						sent      <= sent + 1'b1;
						o_rd_addr <= o_rd_addr + 1'b1;
					end
				end
			end else begin
				o_dacdat <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			shift <= i_rd_data;
		end else if (bits_left != '0) begin
			shift <= {shift[SAMPLE_W-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* rtl/aud_recorder.sv */
`timescale 1ns/1ns
`default_nettype none

module aud_recorder #(
	parameter int ADDR_W = 10
) (
	input  wire                           i_clk,
	input  wire                           i_rst_n,
	input  wire                           i_lrc,
	input  wire                           i_adcdat,
	input  wire                           i_start,
	input  wire                           i_pause,
	input  wire                           i_stop,
	input  wire  [ADDR_W:0]               i_limit,
	output logic                          o_wr_en,
	output logic [ADDR_W-1:0]             o_wr_addr,
	output logic [audio_pkg::SAMPLE_W-1:0] o_wr_data,
	output logic [ADDR_W:0]               o_count,
	output audio_pkg::rec_state_e         o_state,
	output logic                          o_done
);

	localparam int SAMPLE_W = audio_pkg::SAMPLE_W;
	localparam int CNT_W    = $clog2(SAMPLE_W);

	logic                lrc_q;
	logic                lrc_fall;
	logic [CNT_W-1:0]    bit_cnt;
	logic                last_bit;
	logic [SAMPLE_W-1:0] shift;
	logic [SAMPLE_W-1:0] sample;

	assign lrc_fall = lrc_q & ~i_lrc;
	assign last_bit = (bit_cnt == CNT_W'(SAMPLE_W - 1));
	assign sample   = {shift[SAMPLE_W-2:0], i_adcdat};    // MSB arrives first

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lrc_q   <= 1'b0;
			o_state <= audio_pkg::REC_STOPPED;
			bit_cnt <= '0;
			o_count <= '0;
			o_done  <= 1'b0;
			o_wr_en <= 1'b0;
		end else begin
			lrc_q   <= i_lrc;
			o_wr_en <= 1'b0;
			if (i_stop) begin
				o_state <= audio_pkg::REC_STOPPED;
			end else if (i_pause && (o_state == audio_pkg::REC_WAITING ||
					o_state == audio_pkg::REC_CAPTURING)) begin
				o_state <= audio_pkg::REC_PAUSED;    // Partial frame is dropped
			end else begin
				case (o_state)
					audio_pkg::REC_STOPPED: begin
						if (i_start) begin
							o_count <= '0;
							o_done  <= 1'b0;
							o_state <= audio_pkg::REC_WAITING;
						end
					end
					audio_pkg::REC_PAUSED: begin
						if (i_start) begin
							o_state <= audio_pkg::REC_WAITING;    // Count kept
						end
					end
					audio_pkg::REC_WAITING: begin
						if (o_count >= i_limit) begin
							o_state <= audio_pkg::REC_STOPPED;
							o_done  <= 1'b1;
						end else if (lrc_fall) begin
							bit_cnt <= '0;
							o_state <= audio_pkg::REC_CAPTURING;
						end
					end
					audio_pkg::REC_CAPTURING: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							if (o_count >= i_limit) begin
								// Limit was lowered during this frame
								o_state <= audio_pkg::REC_STOPPED;
								o_done  <= 1'b1;
							end else begin
								o_wr_en <= 1'b1;
								o_count <= o_count + 1'b1;
								if (o_count + 1'b1 >= i_limit) begin
									o_state <= audio_pkg::REC_STOPPED;
									o_done  <= 1'b1;
								end else begin
									o_state <= audio_pkg::REC_WAITING;
								end
							end
						end
					end
					default: o_state <= audio_pkg::REC_STOPPED;
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_state == audio_pkg::REC_CAPTURING) begin
			shift <= sample;
		end
		if (o_state == audio_pkg::REC_CAPTURING && last_bit) begin
			o_wr_data <= sample;
			o_wr_addr <= o_count[ADDR_W-1:0];    // Samples stored so far
		end
	end

endmodule

`default_nettype wire

/* rtl/aud_top.sv */
`timescale 1ns/1ns
`default_nettype none

module aud_top #(
	parameter int ADDR_W = 10
) (
	input  wire                                i_clk,    // Codec bit clock
	input  wire                                i_rst_n,
	input  wire                                i_awvalid,
	input  wire  [audio_pkg::AXI_ADDR_W-1:0]   i_awaddr,
	input  wire                                i_wvalid,
	input  wire  [audio_pkg::AXI_DATA_W-1:0]   i_wdata,
	input  wire  [audio_pkg::AXI_DATA_W/8-1:0] i_wstrb,
	input  wire                                i_bready,
	input  wire                                i_arvalid,
	input  wire  [audio_pkg::AXI_ADDR_W-1:0]   i_araddr,
	input  wire                                i_rready,
	output logic                               o_awready,
	output logic                               o_wready,
	output logic                               o_bvalid,
	output logic [1:0]                         o_bresp,
	output logic                               o_arready,
	output logic                               o_rvalid,
	output logic [audio_pkg::AXI_DATA_W-1:0]   o_rdata,
	output logic [1:0]                         o_rresp,
	input  wire                                i_lrc,
	input  wire                                i_adcdat,
	output logic                               o_dacdat
);

	localparam int SAMPLE_W = audio_pkg::SAMPLE_W;

	logic                  start, pause, stop, play;
	logic [ADDR_W:0]       limit;
	logic [ADDR_W:0]       count;
	logic                  done;
	logic                  busy;
	audio_pkg::rec_state_e rec_state;
	logic                  wr_en;
	logic [ADDR_W-1:0]     wr_addr;
	logic [SAMPLE_W-1:0]   wr_data;
	logic [ADDR_W-1:0]     host_rd_addr;
	logic [SAMPLE_W-1:0]   host_rd_data;
	logic [ADDR_W-1:0]     play_rd_addr;
	logic [SAMPLE_W-1:0]   play_rd_data;

	aud_ctrl_regs #(.ADDR_W(ADDR_W)) aud_ctrl_regs_inst (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_awvalid(i_awvalid), .i_awaddr(i_awaddr), .i_wvalid(i_wvalid), .i_wdata(i_wdata),
		.i_wstrb(i_wstrb), .i_bready(i_bready), .i_arvalid(i_arvalid), .i_araddr(i_araddr),
		.i_rready(i_rready), .o_awready(o_awready), .o_wready(o_wready), .o_bvalid(o_bvalid),
		.o_bresp(o_bresp), .o_arready(o_arready), .o_rvalid(o_rvalid), .o_rdata(o_rdata),
		.o_rresp(o_rresp), .o_start(start), .o_pause(pause), .o_stop(stop), .o_play(play),
		.o_limit(limit), .o_rd_addr(host_rd_addr), .i_state(rec_state), .i_count(count),
		.i_done(done), .i_busy(busy), .i_rd_data(host_rd_data)
	);

	aud_recorder #(.ADDR_W(ADDR_W)) aud_recorder_inst (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_lrc(i_lrc), .i_adcdat(i_adcdat),
		.i_start(start), .i_pause(pause), .i_stop(stop), .i_limit(limit),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
		.o_count(count), .o_state(rec_state), .o_done(done)
	);

	aud_player #(.ADDR_W(ADDR_W)) aud_player_inst (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_lrc(i_lrc), .i_play(play), .i_count(count),
		.i_rd_data(play_rd_data), .o_rd_addr(play_rd_addr), .o_dacdat(o_dacdat), .o_busy(busy)
	);

	sample_ram #(.ADDR_W(ADDR_W)) sample_ram_inst (
		.i_clk(i_clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_addr_a(host_rd_addr), .i_rd_addr_b(play_rd_addr),
		.o_rd_data_a(host_rd_data), .o_rd_data_b(play_rd_data)
	);

endmodule

`default_nettype wire

/* rtl/audio_pkg.sv */
`default_nettype none

package audio_pkg;

	localparam int SAMPLE_W   = 16;     // One mono sample
	localparam int AXI_ADDR_W = 8;
	localparam int AXI_DATA_W = 32;

	typedef enum logic [1:0] {
		REC_STOPPED   = 2'd0,
		REC_PAUSED    = 2'd1,
		REC_WAITING   = 2'd2,           // Armed, looking for LRC fall
		REC_CAPTURING = 2'd3
	} rec_state_e;

	// Register map, byte offsets
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 8'h00;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h04;
	localparam logic [AXI_ADDR_W-1:0] REG_LIMIT  = 8'h08;
	localparam logic [AXI_ADDR_W-1:0] REG_RDADDR = 8'h0C;
	localparam logic [AXI_ADDR_W-1:0] REG_RDDATA = 8'h10;

	// REG_CTRL bits, each one a command pulse
	localparam int CTRL_START = 0;
	localparam int CTRL_PAUSE = 1;
	localparam int CTRL_STOP  = 2;
	localparam int CTRL_PLAY  = 3;

	// REG_STATUS fields
	localparam int STAT_REC_STATE = 0;  // Two bits
	localparam int STAT_PLAYING   = 2;
	localparam int STAT_DONE      = 3;
	localparam int STAT_COUNT     = 16; // Recorded sample count

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* rtl/sample_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_ram #(
	parameter int ADDR_W = 10
) (
	input  wire                            i_clk,
	input  wire                            i_wr_en,
	input  wire  [ADDR_W-1:0]              i_wr_addr,
	input  wire  [audio_pkg::SAMPLE_W-1:0] i_wr_data,
	input  wire  [ADDR_W-1:0]              i_rd_addr_a,
	input  wire  [ADDR_W-1:0]              i_rd_addr_b,
	output logic [audio_pkg::SAMPLE_W-1:0] o_rd_data_a,
	output logic [audio_pkg::SAMPLE_W-1:0] o_rd_data_b
);

	localparam int SAMPLE_W = audio_pkg::SAMPLE_W;
	localparam int DEPTH    = 2 ** ADDR_W;

	logic [SAMPLE_W-1:0] mem [DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// Host readback
	always_ff @(posedge i_clk) begin
		o_rd_data_a <= mem[i_rd_addr_a];
	end

	// Playback
	always_ff @(posedge i_clk) begin
		o_rd_data_b <= mem[i_rd_addr_b];
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module aud_tb -f build.f -o aud_sim

sim_out=$(./obj_dir/aud_sim 2>&1 || true)
echo "$sim_out"

grep -qx '\*\* PASS \*\*' <<< "$sim_out"

/* tb/aud_props.sv */
`timescale 1ns/1ns
`default_nettype none

module aud_props #(
	parameter int ADDR_W = 10
) (
	input wire              i_clk,
	input wire              i_rst_n,
	input wire              i_wr_en,
	input wire [ADDR_W-1:0] i_wr_addr,
	input wire [ADDR_W:0]   i_limit,
	input wire              i_bvalid,
	input wire              i_bready,
	input wire              i_rvalid,
	input wire              i_rready
);

	// At most one stored sample per frame
	wr_strobe_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wr_en |=> !i_wr_en)
		else $error("write strobe stayed high for a second cycle");

	wr_addr_below_limit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wr_en |-> ({1'b0, i_wr_addr} < i_limit))
		else $error("write address %0h reached limit %0h", i_wr_addr, i_limit);

	// Responses wait for the host
	bvalid_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_bvalid && !i_bready) |=> i_bvalid)
		else $error("BVALID dropped before the host accepted it");

	rvalid_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_rvalid && !i_rready) |=> i_rvalid)
		else $error("RVALID dropped before the host accepted it");

endmodule

`default_nettype wire

/* tb/aud_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module aud_tb;

	localparam int ADDR_W         = 10;
	localparam int SEED           = 32'h1807c60d;
	localparam int TIMEOUT_CYCLES = 4000;    // About 40 frames plus host traffic
	localparam logic [31:0] CMD_START = 32'h1 << audio_pkg::CTRL_START;
	localparam logic [31:0] CMD_PAUSE = 32'h1 << audio_pkg::CTRL_PAUSE;
	localparam logic [31:0] CMD_STOP  = 32'h1 << audio_pkg::CTRL_STOP;
	localparam logic [31:0] CMD_PLAY  = 32'h1 << audio_pkg::CTRL_PLAY;

	logic        clk, rst_n;
	logic        awvalid, wvalid, bready, arvalid, rready;
	logic [7:0]  awaddr, araddr;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        awready, wready, bvalid, arready, rvalid;
	logic [1:0]  bresp, rresp;
	logic [31:0] rdata;
	logic        lrc, adcdat, dacdat;

	logic [15:0] exp_q [$];             // Samples the recorder should keep
	logic [15:0] stored [2**ADDR_W];
	logic        capture_on;
	int          rec_limit;
	int          cycles = 0;

	aud_top #(.ADDR_W(ADDR_W)) aud_top_inst (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_awvalid(awvalid), .i_awaddr(awaddr), .i_wvalid(wvalid), .i_wdata(wdata),
		.i_wstrb(wstrb), .i_bready(bready), .i_arvalid(arvalid), .i_araddr(araddr),
		.i_rready(rready), .o_awready(awready), .o_wready(wready), .o_bvalid(bvalid),
		.o_bresp(bresp), .o_arready(arready), .o_rvalid(rvalid), .o_rdata(rdata),
		.o_rresp(rresp), .i_lrc(lrc), .i_adcdat(adcdat), .o_dacdat(dacdat)
	);

	// Watches the recorder write port and both host response channels
	bind aud_top aud_props #(.ADDR_W(ADDR_W)) aud_props_inst (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
		.i_limit(limit), .i_bvalid(o_bvalid), .i_bready(i_bready),
		.i_rvalid(o_rvalid), .i_rready(i_rready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			stop_on_error("Timeout: the tests did not finish within the cycle limit");
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else
			stop_on_error($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
	endtask

	// 64-clock LRC frame, sample bits follow the falling edge MSB first
	task automatic codec_model();
		logic [15:0] smp;
		forever begin
			@(negedge clk);
			lrc = 1'b0;
			smp = 16'($urandom);
			if (capture_on && exp_q.size() < rec_limit) begin
				exp_q.push_back(smp);
			end
			for (int b = 15; b >= 0; b--) begin
				@(negedge clk);
				adcdat = smp[b];
			end
			repeat (16) @(negedge clk);
			lrc = 1'b1;
			repeat (31) @(negedge clk);
		end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int unsigned gap;
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hf;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(posedge clk);
		check_word("o_awready", 32'(awready), 32'h1);    // AW and W taken together
		check_word("o_wready", 32'(wready), 32'h1);
		@(negedge clk);
		check_word("o_bvalid", 32'(bvalid), 32'h1);
		check_word("o_awready (response pending)", 32'(awready), 32'h0);
		check_word("o_wready (response pending)", 32'(wready), 32'h0);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		resp    = bresp;
		gap     = $urandom_range(3, 0);    // Back-pressure on B
		repeat (gap) @(negedge clk);
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int unsigned gap;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		@(posedge clk);
		check_word("o_arready", 32'(arready), 32'h1);
		@(negedge clk);
		check_word("o_rvalid", 32'(rvalid), 32'h1);
		check_word("o_arready (response pending)", 32'(arready), 32'h0);
		arvalid = 1'b0;
		gap     = $urandom_range(3, 0);
		repeat (gap) @(negedge clk);
		data   = rdata;                    // Value at the accepting edge
		resp   = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_word("o_bresp", 32'(resp), 32'h0);
	endtask

	function automatic logic [31:0] status_word(input logic [1:0] state,
			input logic playing, input logic done, input int count);
		logic [31:0] w;
		w = '0;
		w[audio_pkg::STAT_REC_STATE +: 2] = state;
		w[audio_pkg::STAT_PLAYING]        = playing;
		w[audio_pkg::STAT_DONE]           = done;
		w[audio_pkg::STAT_COUNT +: 16]    = 16'(count);
		return w;
	endfunction

	task automatic check_status(input logic [1:0] state, input logic playing,
			input logic done, input int count);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(audio_pkg::REG_STATUS, data, resp);
		check_word("o_rdata (REG_STATUS)", data, status_word(state, playing, done, count));
	endtask

	task automatic check_stored(input int n);
		logic [31:0] data;
		logic [1:0]  resp;
		for (int a = 0; a < n; a++) begin
			write_ok(audio_pkg::REG_RDADDR, 32'(a));
			axi_read(audio_pkg::REG_RDDATA, data, resp);
			check_word("o_rresp", 32'(resp), 32'h0);
			check_word($sformatf("o_rdata (sample %0d)", a), data, {16'h0, stored[a]});
		end
	endtask

	task automatic run_until(input int n);
		while (exp_q.size() < n) @(posedge lrc);
	endtask

	task automatic keep_samples();
		foreach (exp_q[i]) stored[i] = exp_q[i];
	endtask

	initial begin
		logic [31:0] data;
		logic [1:0]  resp;
		void'($urandom(SEED));
		rst_n      = 1'b0;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		bready     = 1'b0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		lrc        = 1'b0;
		adcdat     = 1'b0;
		capture_on = 1'b0;
		rec_limit  = 2 ** ADDR_W;
		fork
			codec_model();
		join_none
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_word("o_dacdat", 32'(dacdat), 32'h0);
		check_word("o_bvalid", 32'(bvalid), 32'h0);
		check_word("o_rvalid", 32'(rvalid), 32'h0);
		check_status(audio_pkg::REC_STOPPED, 1'b0, 1'b0, 0);

		// Plain recording of 8 frames
		@(posedge lrc);
		capture_on = 1'b1;
		write_ok(audio_pkg::REG_CTRL, CMD_START);
		run_until(8);
		capture_on = 1'b0;
		write_ok(audio_pkg::REG_CTRL, CMD_STOP);
		keep_samples();
		check_status(audio_pkg::REC_STOPPED, 1'b0, 1'b0, 8);
		check_stored(8);

		// Pause drops two frames, resume continues at the next address
		@(posedge lrc);
		exp_q.delete();
		capture_on = 1'b1;
		write_ok(audio_pkg::REG_CTRL, CMD_START);
		run_until(3);
		capture_on = 1'b0;
		write_ok(audio_pkg::REG_CTRL, CMD_PAUSE);
		check_status(audio_pkg::REC_PAUSED, 1'b0, 1'b0, 3);
		repeat (2) @(posedge lrc);
		capture_on = 1'b1;
		write_ok(audio_pkg::REG_CTRL, CMD_START);
		run_until(6);
		capture_on = 1'b0;
		write_ok(audio_pkg::REG_CTRL, CMD_STOP);
		keep_samples();
		check_stored(6);

		// Sample limit ends recording on its own
		write_ok(audio_pkg::REG_LIMIT, 32'd5);
		rec_limit = 5;
		@(posedge lrc);
		exp_q.delete();
		capture_on = 1'b1;
		write_ok(audio_pkg::REG_CTRL, CMD_START);
		run_until(5);
		@(posedge lrc);                     // A sixth frame passes unrecorded
		capture_on = 1'b0;
		keep_samples();
		check_status(audio_pkg::REC_STOPPED, 1'b0, 1'b1, 5);
		check_stored(6);                    // Address 5 keeps the earlier take

		// Playback of the 5 stored samples
		@(posedge lrc);
		write_ok(audio_pkg::REG_CTRL, CMD_PLAY);
		check_status(audio_pkg::REC_STOPPED, 1'b1, 1'b1, 5);
		for (int f = 0; f < 5; f++) begin
			@(negedge lrc);
			@(negedge clk);
			check_word("o_dacdat (before first bit)", 32'(dacdat), 32'h0);
			for (int b = 15; b >= 0; b--) begin
				@(negedge clk);
				check_word($sformatf("o_dacdat (sample %0d bit %0d)", f, b),
					32'(dacdat), 32'(stored[f][b]));
			end
		end
		@(posedge lrc);
		check_status(audio_pkg::REC_STOPPED, 1'b0, 1'b1, 5);

		// Host error responses
		axi_read(8'h20, data, resp);
		check_word("o_rresp (unmapped)", 32'(resp), 32'h2);    // SLVERR
		write_ok(audio_pkg::REG_STATUS, 32'hffff_ffff);
		check_status(audio_pkg::REC_STOPPED, 1'b0, 1'b1, 5);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
